// File: include/arm_decode.svh
`ifndef arm_decode_svh
`define arm_decode_svh

// casez patterns for the instruction classes seen by the memory stage
// cond field [31:28] is ignored

// ldr, str, ldrb, strb
`define decode_ldrstr 32'b????01??????????????????????????

// register offset form with bit 4 set, undefined on arm
// must be matched before decode_ldrstr
`define decode_ldrstr_undefined 32'b????011????????????????????1????

// ldm, stm
`define decode_ldmstm 32'b????100?????????????????????????

`endif

// File: source/arm_ls_pkg.sv
package arm_ls_pkg;

	// ----------------------------------------
	// data and instruction types
	// ----------------------------------------
	typedef logic [31:0] word_t;
	typedef logic [3:0] reg_idx_t;
	typedef logic [31:0] insn_t;

	// ----------------------------------------
	// single data transfer field positions
	// ----------------------------------------
	// load when set, store when clear
	localparam int bit_l = 20;
	// write the offset address back to rn
	localparam int bit_w = 21;
	localparam int bit_b = 22;
	// up: base + offset, down: base - offset
	localparam int bit_u = 23;
	// pre-index when set, post-index when clear
	localparam int bit_p = 24;

	localparam int rn_lsb = 16;
	localparam int rd_lsb = 12;

	// memory stage sequencing
	typedef enum logic [1:0] {
		idle,
		wait_bus,
		base_wb
	} ls_state_t;

endpackage

// File: source/mem_stage.sv
`timescale 1ns/1ns

`include "arm_decode.svh"

module mem_stage import arm_ls_pkg::*; (
	input  logic       clk,
	input  logic       rst,
	input  word_t      pc,
	input  insn_t      insn,
	input  word_t      base,
	input  word_t      offset,
	input  logic       rw_wait,
	input  word_t      rd_data,
	input  word_t      st_data,
	output word_t      busaddr,
	output logic       rd_req,
	output logic       wr_req,
	output word_t      wr_data,
	output logic [3:0] wr_be,
	output reg_idx_t   st_read,
	output logic       writeback,
	output reg_idx_t   regsel,
	output word_t      regdata,
	output word_t      outpc,
	output logic       outstall,
	output logic       outbubble
);

	ls_state_t state, state_nxt;

	logic is_ls, is_load, is_byte, base_upd;
	logic active, done, base_done;
	logic wb_nxt;
	reg_idx_t rn, rd, sel_nxt;
	word_t off_addr, xfer_addr, load_data, data_nxt;
	logic [63:0] rot_pair;

	// ----------------------------------------
	// decode
	// ----------------------------------------
	always_comb begin
		is_ls = 1'b0;
		casez (insn)
			`decode_ldrstr_undefined: is_ls = 1'b0;
			`decode_ldrstr: is_ls = 1'b1;
			// block transfers pass through as a no-op
			`decode_ldmstm: is_ls = 1'b0;
			default: is_ls = 1'b0;
		endcase
	end

	assign is_load = insn[bit_l];
	assign is_byte = insn[bit_b];
	// post-indexed forms always update the base
	assign base_upd = insn[bit_w] | ~insn[bit_p];
	assign rn = insn[rn_lsb +: 4];
	assign rd = insn[rd_lsb +: 4];

	// ----------------------------------------
	// address generation and bus
	// ----------------------------------------
	assign off_addr = insn[bit_u] ? base + offset : base - offset;
	assign xfer_addr = insn[bit_p] ? off_addr : base;
	assign busaddr = {xfer_addr[31:2], 2'b00};

	// no new request while the base update is pending or just written
	assign active = is_ls & (state != base_wb) & ~base_done;
	assign rd_req = active & is_load;
	assign wr_req = active & ~is_load;
	assign done = active & ~rw_wait;

	assign st_read = rd;
	assign wr_data = is_byte ? {4{st_data[7:0]}} : st_data;
	assign wr_be = is_byte ? 4'b0001 << xfer_addr[1:0] : 4'b1111;

	// rotate right by whole bytes, then trim for ldrb
	assign rot_pair = {rd_data, rd_data} >> {xfer_addr[1:0], 3'b000};
	assign load_data = is_byte ? {24'h0, rot_pair[7:0]} : rot_pair[31:0];

	assign outstall = rw_wait | (state == base_wb) | (done & is_load & base_upd);

	// ----------------------------------------
	// sequencing and writeback
	// ----------------------------------------
	always_comb begin
		state_nxt = state;
		case (state)
			idle, wait_bus: begin
				if (done)
					state_nxt = (is_load & base_upd) ? base_wb : idle;
				else if (active)
					state_nxt = wait_bus;
				else
					state_nxt = idle;
			end
			base_wb: state_nxt = idle;
			default: state_nxt = idle;
		endcase
	end

	always_comb begin
		wb_nxt = 1'b0;
		sel_nxt = rd;
		data_nxt = load_data;
		if (state == base_wb) begin
			wb_nxt = 1'b1;
			sel_nxt = rn;
			data_nxt = off_addr;
		end else if (done & is_load) begin
			wb_nxt = 1'b1;
		end else if (done & base_upd) begin
			// store with base update goes out right away
			wb_nxt = 1'b1;
			sel_nxt = rn;
			data_nxt = off_addr;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= idle;
			writeback <= 1'b0;
			outbubble <= 1'b0;
			base_done <= 1'b0;
		end else begin
			state <= state_nxt;
			writeback <= wb_nxt;
			outbubble <= rw_wait;
			base_done <= (state == base_wb);
		end
	end

	always_ff @(posedge clk) begin
		outpc <= pc;
		regsel <= sel_nxt;
		regdata <= data_nxt;
	end

endmodule

// File: source/reg_file.sv
`timescale 1ns/1ns

module reg_file import arm_ls_pkg::*; (
	input  logic     clk,
	input  logic     rst,
	input  reg_idx_t st_read,
	input  logic     wb_en,
	input  reg_idx_t wb_sel,
	input  word_t    wb_data,
	input  logic     rf_we,
	input  reg_idx_t rf_waddr,
	input  word_t    rf_wdata,
	output word_t    st_data
);

	word_t regs [16];

	// store data read, no clock
	assign st_data = regs[st_read];

	// ----------------------------------------
	// write ports
	// ----------------------------------------
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < 16; i++) begin
				regs[i] <= '0;
			end
		end else begin
			if (rf_we) begin
				regs[rf_waddr] <= rf_wdata;
			end
			// memory writeback last so it wins on the same register
			if (wb_en) begin
				regs[wb_sel] <= wb_data;
			end
		end
	end

endmodule

// File: source/data_ram.sv
`timescale 1ns/1ns

module data_ram import arm_ls_pkg::*; #(
	parameter int addr_words = 256,
	parameter int wait_cycles = 2
) (
	input  logic       clk,
	input  logic       rst,
	input  word_t      busaddr,
	input  logic       rd_req,
	input  logic       wr_req,
	input  word_t      wr_data,
	input  logic [3:0] wr_be,
	output logic       rw_wait,
	output word_t      rd_data
);

	localparam int idx_w = (addr_words > 1) ? $clog2(addr_words) : 1;
	localparam int cnt_w = (wait_cycles > 0) ? $clog2(wait_cycles + 1) : 1;

	word_t mem [addr_words];

	logic [idx_w-1:0] widx;
	logic [cnt_w-1:0] cnt;
	logic armed, req, xfer;

	assign widx = idx_w'((busaddr >> 2) % addr_words);
	assign req = rd_req | wr_req;

	// ----------------------------------------
	// wait state counter
	// ----------------------------------------
	// first request cycle already waits when wait_cycles is nonzero
	assign rw_wait = req & (armed ? (cnt != '0) : (wait_cycles != 0));
	assign xfer = req & ~rw_wait;

	always_ff @(posedge clk) begin
		if (rst) begin
			armed <= 1'b0;
			cnt <= '0;
		end else if (xfer) begin
			armed <= 1'b0;
		end else if (req & ~armed) begin
			armed <= 1'b1;
			cnt <= cnt_w'(wait_cycles - 1);
		end else if (armed & (cnt != '0)) begin
			cnt <= cnt - 1'b1;
		end
	end

	// ----------------------------------------
	// storage
	// ----------------------------------------
	assign rd_data = mem[widx];

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < addr_words; i++) begin
				mem[i] <= '0;
			end
		end else if (xfer & wr_req) begin
			for (int b = 0; b < 4; b++) begin
				if (wr_be[b])
					mem[widx][b*8 +: 8] <= wr_data[b*8 +: 8];
			end
		end
	end

endmodule

// File: source/ls_unit_top.sv
`timescale 1ns/1ns

module ls_unit_top import arm_ls_pkg::*; #(
	parameter int addr_words = 256,
	parameter int wait_cycles = 2
) (
	input  logic       clk,
	input  logic       rst,
	input  word_t      pc,
	input  insn_t      insn,
	input  word_t      base,
	input  word_t      offset,
	input  logic       rf_we,
	input  reg_idx_t   rf_waddr,
	input  word_t      rf_wdata,
	output word_t      outpc,
	output logic       outstall,
	output logic       outbubble,
	output logic       writeback,
	output reg_idx_t   regsel,
	output word_t      regdata,
	output word_t      busaddr,
	output logic       rd_req,
	output logic       wr_req,
	output word_t      wr_data,
	output logic [3:0] wr_be,
	output logic       rw_wait
);

	word_t rd_data, st_data;
	reg_idx_t st_read;

	mem_stage mem0 (
		.clk(clk), .rst(rst),
		.pc(pc), .insn(insn), .base(base), .offset(offset),
		.rw_wait(rw_wait), .rd_data(rd_data), .st_data(st_data),
		.busaddr(busaddr), .rd_req(rd_req), .wr_req(wr_req),
		.wr_data(wr_data), .wr_be(wr_be), .st_read(st_read),
		.writeback(writeback), .regsel(regsel), .regdata(regdata),
		.outpc(outpc), .outstall(outstall), .outbubble(outbubble)
	);

	reg_file rf0 (
		.clk(clk), .rst(rst), .st_read(st_read),
		.wb_en(writeback), .wb_sel(regsel), .wb_data(regdata),
		.rf_we(rf_we), .rf_waddr(rf_waddr), .rf_wdata(rf_wdata),
		.st_data(st_data)
	);

	data_ram #(.addr_words(addr_words), .wait_cycles(wait_cycles)) ram0 (
		.clk(clk), .rst(rst), .busaddr(busaddr),
		.rd_req(rd_req), .wr_req(wr_req), .wr_data(wr_data), .wr_be(wr_be),
		.rw_wait(rw_wait), .rd_data(rd_data)
	);

endmodule

// File: testbench/ls_unit_assert.sv
`timescale 1ns/1ns

module ls_unit_assert import arm_ls_pkg::*; (
	input logic  clk,
	input logic  rst,
	input logic  rd_req,
	input logic  wr_req,
	input word_t busaddr,
	input logic  rw_wait,
	input logic  outstall,
	input logic  writeback
);

	one_request: assert property (@(posedge clk) disable iff (rst) !(rd_req && wr_req))
		else $error("rd_req and wr_req high in the same cycle");

	aligned_addr: assert property (@(posedge clk) disable iff (rst)
		(rd_req || wr_req) |-> busaddr[1:0] == 2'b00)
		else $error("request with busaddr not word aligned");

	wait_stalls: assert property (@(posedge clk) disable iff (rst) rw_wait |-> outstall)
		else $error("rw_wait high while outstall is low");

	// first cycle out of reset
	quiet_after_reset: assert property (@(posedge clk) $past(rst) |-> !writeback)
		else $error("writeback high right after reset");

endmodule

bind mem_stage ls_unit_assert asrt0 (
	.clk(clk), .rst(rst), .rd_req(rd_req), .wr_req(wr_req), .busaddr(busaddr),
	.rw_wait(rw_wait), .outstall(outstall), .writeback(writeback)
);

// File: testbench/ls_unit_checker.sv
`timescale 1ns/1ns

`include "arm_decode.svh"

module ls_unit_checker import arm_ls_pkg::*; #(
	parameter int addr_words = 256
) (
	input logic       clk,
	input logic       rst,
	input word_t      pc,
	input insn_t      insn,
	input word_t      base,
	input word_t      offset,
	input logic       rf_we,
	input reg_idx_t   rf_waddr,
	input word_t      rf_wdata,
	input word_t      busaddr,
	input logic       rd_req,
	input logic       wr_req,
	input word_t      wr_data,
	input logic [3:0] wr_be,
	input logic       rw_wait,
	input logic       outstall,
	input word_t      outpc,
	input logic       outbubble,
	input logic       writeback,
	input reg_idx_t   regsel,
	input word_t      regdata,
	input logic       test_done,
	input int         test_id,
	output int        errors
);

	word_t mem [addr_words];
	word_t regs [16];
	reg_idx_t exp_sel [$];
	word_t exp_data [$];
	int xfers;
	int errs_test;
	logic saw_ls;
	word_t last_pc;
	logic last_wait;

	function automatic logic decodes_ls(insn_t i);
		casez (i)
			`decode_ldrstr_undefined: return 1'b0;
			`decode_ldrstr: return 1'b1;
			default: return 1'b0;
		endcase
	endfunction

	task automatic complain(input string what);
		$display("error: %s", what);
		errors++;
		errs_test++;
	endtask

	task automatic compare(input string name, input word_t got, input word_t exp);
		if (got !== exp)
			complain_value(name, got, exp);
	endtask

	task automatic complain_value(input string name, input word_t got, input word_t exp);
		$display("[FAIL] %s: got %h, expected %h", name, got, exp);
		errors++;
		errs_test++;
	endtask

	// ----------------------------------------
	// one completed bus transfer
	// ----------------------------------------
	task automatic check_transfer();
		word_t off_addr, xfer_addr, w, exp_wd;
		logic [3:0] exp_be;
		reg_idx_t rn, rd;
		int idx, sh;
		logic lane_on;
		rn = insn[rn_lsb +: 4];
		rd = insn[rd_lsb +: 4];
		off_addr = insn[bit_u] ? base + offset : base - offset;
		xfer_addr = insn[bit_p] ? off_addr : base;
		sh = 8 * int'(xfer_addr[1:0]);
		idx = int'((xfer_addr >> 2) % addr_words);
		compare("busaddr", busaddr, {xfer_addr[31:2], 2'b00});
		if (rd_req !== insn[bit_l])
			complain("request type does not follow the L bit");
		if (insn[bit_l]) begin
			w = mem[idx];
			w = (w >> sh) | (w << (32 - sh));
			if (insn[bit_b])
				w = w & 32'h0000_00ff;
			exp_sel.push_back(rd);
			exp_data.push_back(w);
		end else begin
			for (int b = 0; b < 4; b++) begin
				lane_on = !insn[bit_b] || (b == int'(xfer_addr[1:0]));
				exp_be[b] = lane_on;
				exp_wd[b*8 +: 8] = insn[bit_b] ? regs[rd][7:0] : regs[rd][b*8 +: 8];
				if (lane_on)
					mem[idx][b*8 +: 8] = exp_wd[b*8 +: 8];
			end
			compare("wr_be", word_t'(wr_be), word_t'(exp_be));
			compare("wr_data", wr_data, exp_wd);
		end
		// post-index always writes the base back
		if (insn[bit_w] || !insn[bit_p]) begin
			exp_sel.push_back(rn);
			exp_data.push_back(off_addr);
		end
	endtask

	always @(negedge clk) begin
		if (rst) begin
			for (int i = 0; i < addr_words; i++)
				mem[i] = '0;
			for (int i = 0; i < 16; i++)
				regs[i] = '0;
			exp_sel.delete();
			exp_data.delete();
			xfers = 0;
			errs_test = 0;
			saw_ls = 1'b0;
			errors = 0;
			last_pc = pc;
			last_wait = 1'b0;
		end else begin
			// one cycle delayed copies of pc and rw_wait
			compare("outpc", outpc, last_pc);
			compare("outbubble", word_t'(outbubble), word_t'(last_wait));
			last_pc = pc;
			last_wait = rw_wait;
			if (rw_wait && !outstall)
				complain("rw_wait high without outstall");
			if (decodes_ls(insn))
				saw_ls = 1'b1;
			else if (outstall || rd_req || wr_req)
				complain("stall or request on a non-transfer instruction");
			if ((rd_req || wr_req) && !rw_wait) begin
				xfers++;
				check_transfer();
			end
			if (rf_we)
				regs[rf_waddr] = rf_wdata;
			// memory writeback lands after the outside port
			if (writeback) begin
				if (exp_sel.size() == 0) begin
					complain("writeback with nothing pending");
				end else begin
					compare("regsel", word_t'(regsel), word_t'(exp_sel[0]));
					compare("regdata", regdata, exp_data[0]);
					regs[exp_sel.pop_front()] = exp_data.pop_front();
				end
			end
			if (test_done) begin
				if (xfers != (saw_ls ? 1 : 0))
					complain($sformatf("saw %0d transfers, expected %0d", xfers, saw_ls ? 1 : 0));
				if (exp_sel.size() != 0)
					complain("expected writeback never appeared");
				if (errs_test == 0)
					$display("test %0d: ok", test_id);
				else
					$display("test %0d: %0d errors", test_id, errs_test);
				exp_sel.delete();
				exp_data.delete();
				xfers = 0;
				errs_test = 0;
				saw_ls = 1'b0;
			end
		end
	end

endmodule

// File: testbench/ls_unit_tb.sv
`timescale 1ns/1ns

module ls_unit_tb import arm_ls_pkg::*; ();

	localparam int wait_cycles = 2;
	localparam int addr_words = 256;
	localparam int n_tests = 14;

	typedef struct {
		reg_idx_t pre_idx;
		insn_t    insn;
		word_t    base;
		word_t    offset;
	} test_t;

	test_t tbl [n_tests];

	logic clk, rst, rf_we;
	word_t pc, base, offset, rf_wdata, rnd;
	insn_t insn;
	reg_idx_t rf_waddr;
	word_t outpc, regdata, busaddr, wr_data;
	logic outstall, outbubble, writeback, rd_req, wr_req, rw_wait;
	reg_idx_t regsel;
	logic [3:0] wr_be;
	logic test_done;
	int test_id;
	int errors;

	ls_unit_top #(.addr_words(addr_words), .wait_cycles(wait_cycles)) dut0 (
		.clk(clk), .rst(rst), .pc(pc), .insn(insn), .base(base), .offset(offset),
		.rf_we(rf_we), .rf_waddr(rf_waddr), .rf_wdata(rf_wdata),
		.outpc(outpc), .outstall(outstall), .outbubble(outbubble),
		.writeback(writeback), .regsel(regsel), .regdata(regdata),
		.busaddr(busaddr), .rd_req(rd_req), .wr_req(wr_req), .wr_data(wr_data),
		.wr_be(wr_be), .rw_wait(rw_wait)
	);

	ls_unit_checker #(.addr_words(addr_words)) chk0 (
		.clk(clk), .rst(rst), .pc(pc), .insn(insn), .base(base), .offset(offset),
		.rf_we(rf_we), .rf_waddr(rf_waddr), .rf_wdata(rf_wdata),
		.busaddr(busaddr), .rd_req(rd_req), .wr_req(wr_req), .wr_data(wr_data),
		.wr_be(wr_be), .rw_wait(rw_wait), .outstall(outstall),
		.outpc(outpc), .outbubble(outbubble),
		.writeback(writeback), .regsel(regsel), .regdata(regdata),
		.test_done(test_done), .test_id(test_id), .errors(errors)
	);

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// flags are {p, u, b, w, l}, immediate form, always condition
	function automatic insn_t ls_insn(input logic [4:0] flags, input reg_idx_t rn,
			input reg_idx_t rd);
		return {4'he, 3'b010, flags, rn, rd, 12'h000};
	endfunction

	task automatic set_test(input int i, input reg_idx_t pre, input insn_t ins,
			input word_t b, input word_t o);
		tbl[i].pre_idx = pre;
		tbl[i].insn = ins;
		tbl[i].base = b;
		tbl[i].offset = o;
	endtask

	// hold the instruction until outstall is low at an edge
	task automatic wait_accept();
		@(negedge clk);
		while (outstall)
			@(negedge clk);
	endtask

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	initial begin
		repeat (n_tests * (wait_cycles + 8) + 100) @(posedge clk);
		$display("timeout: the tests did not finish within the cycle limit");
		$display("sim failed");
		$finish;
	end

	initial begin
		rst = 1'b1;
		pc = '0;
		insn = '0;
		base = '0;
		offset = '0;
		rf_we = 1'b0;
		rf_waddr = '0;
		rf_wdata = '0;
		test_done = 1'b0;
		test_id = 0;
		rnd = 32'hb08f_bf19;
		// ----------------------------------------
		// stimulus table
		// ----------------------------------------
		set_test(0, 4'd1, ls_insn(5'b11000, 4'd2, 4'd1), 32'h100, 32'h10);
		set_test(1, 4'd3, ls_insn(5'b11001, 4'd2, 4'd3), 32'h100, 32'h10);
		set_test(2, 4'd6, ls_insn(5'b11000, 4'd2, 4'd6), 32'h120, 32'h0);
		set_test(3, 4'd4, ls_insn(5'b11100, 4'd2, 4'd4), 32'h120, 32'h1);
		set_test(4, 4'd5, ls_insn(5'b11001, 4'd2, 4'd5), 32'h120, 32'h0);
		set_test(5, 4'd7, ls_insn(5'b11001, 4'd2, 4'd7), 32'h110, 32'h2);
		set_test(6, 4'd8, ls_insn(5'b11101, 4'd2, 4'd8), 32'h110, 32'h3);
		set_test(7, 4'd9, ls_insn(5'b10000, 4'd2, 4'd9), 32'h200, 32'h20);
		set_test(8, 4'd10, ls_insn(5'b01000, 4'd11, 4'd10), 32'h140, 32'h8);
		set_test(9, 4'd12, ls_insn(5'b00001, 4'd13, 4'd12), 32'h1e0, 32'h4);
		set_test(10, 4'd14, ls_insn(5'b10011, 4'd2, 4'd14), 32'h150, 32'h10);
		set_test(11, 4'd1, ls_insn(5'b11110, 4'd3, 4'd1), 32'h300, 32'h3);
		// register offset with bit 4 set, then an ldm
		set_test(12, 4'd0, 32'he790_0010, 32'h100, 32'h0);
		set_test(13, 4'd0, 32'he890_0006, 32'h100, 32'h0);
		repeat (4) @(posedge clk);
		rst <= 1'b0;
		for (int i = 0; i < n_tests; i++) begin
			rnd = xorshift(rnd);
			@(posedge clk);
			test_done <= 1'b0;
			rf_we <= 1'b1;
			rf_waddr <= tbl[i].pre_idx;
			rf_wdata <= rnd;
			@(posedge clk);
			rf_we <= 1'b0;
			pc <= 32'h8000 + 4 * i;
			insn <= tbl[i].insn;
			base <= tbl[i].base;
			offset <= tbl[i].offset;
			wait_accept();
			@(posedge clk);
			insn <= '0;
			repeat (2) @(posedge clk);
			test_id <= i;
			test_done <= 1'b1;
		end
		@(posedge clk);
		test_done <= 1'b0;
		@(posedge clk);
		$display("%0d tests run, %0d errors", n_tests, errors);
		if (errors == 0)
			$display("sim passed");
		else
			$display("sim failed");
		$finish;
	end

endmodule

// File: verilog.f
+incdir+include
source/arm_ls_pkg.sv
source/mem_stage.sv
source/reg_file.sv
source/data_ram.sv
source/ls_unit_top.sv
testbench/ls_unit_assert.sv
testbench/ls_unit_checker.sv
testbench/ls_unit_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP ?= ls_unit_tb
FILELIST ?= verilog.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, and look for the pass line in $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "sim passed" $(LOG) || (echo "simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
